//--- common/display_pkg.sv
/*
 * display geometry: raster timing, framebuffer size and the
 * display signal and colour types shared by timing and scan-out
 */
`default_nettype none

package display_pkg;

    // raster in pixels and lines, sync active high
    localparam int H_ACTIVE     = 64;
    localparam int H_SYNC_START = 68;
    localparam int H_SYNC_END   = 72;
    localparam int H_TOTAL      = 80;
    localparam int V_ACTIVE     = 36;
    localparam int V_SYNC_START = 37;
    localparam int V_SYNC_END   = 39;
    localparam int V_TOTAL      = 40;

    localparam int CORDW = 8;  // coordinate width, signed

    // framebuffer, each fb pixel covers FB_SCALE x FB_SCALE screen pixels
    localparam int FB_WIDTH  = 32;
    localparam int FB_HEIGHT = 18;
    localparam int FB_SCALE  = 2;
    localparam int FB_ADDRW  = $clog2(FB_WIDTH * FB_HEIGHT);

    typedef logic signed [CORDW-1:0] coord_t;

    typedef struct packed {
        logic   hsync;
        logic   vsync;
        logic   de;     // data enable, active area
        logic   frame;  // one cycle at raster origin
        coord_t sx;
        coord_t sy;
    } disp_sig_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

endpackage

`default_nettype wire

//--- common/draw_pkg.sv
/*
 * drawing definitions: colour index, palette, rectangle type
 * and the constants that pace drawing against the frame rate
 */
`default_nettype none

package draw_pkg;

    localparam int CIDXW = 4;
    typedef logic [CIDXW-1:0] cidx_t;

    // 12-bit palette, entry 0 is the cleared background
    localparam display_pkg::rgb_t PALETTE [16] = '{
        12'h000,  // black
        12'hF22,  // red
        12'h2D2,  // green
        12'h24F,  // blue
        12'hFD1,  // yellow
        12'hF8C,
        12'h1DE,
        12'hA5F,
        12'hF80,
        12'h8F8,
        12'h68C,
        12'hC96,
        12'h777,
        12'hBBB,
        12'h444,
        12'hFFF
    };

    localparam int SHAPE_CNT = 4;
    localparam int SHAPE_IDW = $clog2(SHAPE_CNT);

    typedef struct packed {
        display_pkg::coord_t x0;
        display_pkg::coord_t y0;
        display_pkg::coord_t x1;  // corners inclusive
        display_pkg::coord_t y1;
        cidx_t               cidx;
    } rect_t;

    // drawing speed
    localparam int FRAME_WAIT = 2;   // frames before drawing starts
    localparam int PIX_FRAME  = 64;  // pixel budget per frame
    localparam int WAIT_CNTW  = $clog2(FRAME_WAIT + 1);
    localparam int PIX_CNTW   = $clog2(PIX_FRAME + 1);

endpackage

`default_nettype wire

//--- src/display_timing.sv
/*
 * raster generator: position counters with registered sync,
 * data enable and frame pulse decoded from the display limits
 */
`default_nettype none
`timescale 1ns/1ps

module display_timing (
    input  wire logic              clk_100m,
    input  wire logic              rst_n,
    output display_pkg::disp_sig_t timing
);
    import display_pkg::*;

    coord_t nx;  // next position
    coord_t ny;

    always_comb begin
        nx = timing.sx + coord_t'(1);
        ny = timing.sy;
        if (timing.sx == coord_t'(H_TOTAL - 1)) begin
            nx = '0;
            if (timing.sy == coord_t'(V_TOTAL - 1)) begin
                ny = '0;
            end else begin
                ny = timing.sy + coord_t'(1);
            end
        end
    end

    // flags decoded from the next position so they line up with sx, sy
    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            timing.sx    <= coord_t'(H_TOTAL - 1);  // park in blanking
            timing.sy    <= coord_t'(V_TOTAL - 1);
            timing.hsync <= 1'b0;
            timing.vsync <= 1'b0;
            timing.de    <= 1'b0;
            timing.frame <= 1'b0;
        end else begin
            timing.sx    <= nx;
            timing.sy    <= ny;
            timing.hsync <= (nx >= H_SYNC_START) && (nx < H_SYNC_END);
            timing.vsync <= (ny >= V_SYNC_START) && (ny < V_SYNC_END);
            timing.de    <= (nx < H_ACTIVE) && (ny < V_ACTIVE);
            timing.frame <= (nx == 0) && (ny == 0);
        end
    end

endmodule

`default_nettype wire

//--- draw/shape_sequencer.sv
/*
 * shape sequencer: issues the rectangles one at a time and
 * paces the filler with a per-frame pixel budget
 */
`default_nettype none
`timescale 1ns/1ps

module shape_sequencer (
    input  wire logic      clk_100m,
    input  wire logic      rst_n,
    input  wire logic      frame,
    input  wire logic      draw_done,
    output draw_pkg::rect_t rect,
    output logic           draw_start,
    output logic           draw_oe,
    output logic           draw_done_all
);
    import display_pkg::*;
    import draw_pkg::*;

    typedef enum logic [1:0] {IDLE, LOAD, DRAW, FINISHED} state_t;

    state_t                 state;
    logic [SHAPE_IDW-1:0]   shape_id;
    logic [SHAPE_IDW-1:0]   next_id;
    logic [WAIT_CNTW-1:0]   cnt_wait;
    logic [PIX_CNTW-1:0]    cnt_pix;
    logic                   wait_done;
    logic                   last_shape;
    logic                   load_rect;

    // shape n spans (4+2n, 2+2n) to (14+2n, 10+2n), colour n+1
    function automatic rect_t shape_rect(input logic [SHAPE_IDW-1:0] n);
        rect_t  r;
        coord_t ofs;
        ofs    = coord_t'({n, 1'b0});
        r.x0   = coord_t'(4) + ofs;
        r.y0   = coord_t'(2) + ofs;
        r.x1   = coord_t'(14) + ofs;
        r.y1   = coord_t'(10) + ofs;
        r.cidx = cidx_t'(n) + cidx_t'(1);  // skip black
        return r;
    endfunction

    assign wait_done  = (cnt_wait == WAIT_CNTW'(FRAME_WAIT));
    assign last_shape = (shape_id == SHAPE_IDW'(SHAPE_CNT - 1));
    assign load_rect  = ((state == IDLE) && wait_done) ||
                        ((state == DRAW) && draw_done && !last_shape);
    assign next_id    = (state == IDLE) ? '0 : shape_id + 1'b1;

    always_ff @(posedge clk_100m) begin
        if (load_rect) rect <= shape_rect(next_id);  // start follows a cycle later
    end

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            state         <= IDLE;
            shape_id      <= '0;
            draw_start    <= 1'b0;
            draw_done_all <= 1'b0;
        end else begin
            draw_start <= 1'b0;
            if (load_rect) shape_id <= next_id;
            case (state)
                IDLE: if (wait_done) state <= LOAD;
                LOAD: begin
                    draw_start <= 1'b1;
                    state      <= DRAW;
                end
                DRAW: if (draw_done) begin
                    if (last_shape) begin
                        state         <= FINISHED;
                        draw_done_all <= 1'b1;
                    end else begin
                        state <= LOAD;
                    end
                end
                default: state <= FINISHED;  // stays here for good
            endcase
        end
    end

    // frame wait, then PIX_FRAME enabled cycles after each frame pulse
    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            cnt_wait <= '0;
            cnt_pix  <= '0;
            draw_oe  <= 1'b0;
        end else if (frame) begin
            if (!wait_done) cnt_wait <= cnt_wait + 1'b1;
            cnt_pix <= '0;
            draw_oe <= 1'b0;
        end else if (wait_done && cnt_pix != PIX_CNTW'(PIX_FRAME)) begin
            cnt_pix <= cnt_pix + 1'b1;
            draw_oe <= 1'b1;
        end else begin
            draw_oe <= 1'b0;  // budget spent
        end
    end

endmodule

`default_nettype wire

//--- draw/draw_rectangle_fill.sv
/*
 * filled rectangle walker: scans x then y over the latched corners,
 * one coordinate per cycle while the output enable is high
 */
`default_nettype none
`timescale 1ns/1ps

module draw_rectangle_fill (
    input  wire logic            clk_100m,
    input  wire logic            rst_n,
    input  wire logic            start,
    input  wire logic            oe,
    input  wire draw_pkg::rect_t rect,
    output display_pkg::coord_t  px,
    output display_pkg::coord_t  py,
    output logic                 drawing,
    output logic                 done
);
    import display_pkg::*;

    coord_t x0_q;  // latched corners
    coord_t x1_q;
    coord_t y1_q;
    logic   busy;
    logic   last_pix;

    assign drawing  = busy && oe;
    assign last_pix = (px == x1_q) && (py == y1_q);

    // coordinate walk
    always_ff @(posedge clk_100m) begin
        if (start) begin
            px   <= rect.x0;
            py   <= rect.y0;
            x0_q <= rect.x0;
            x1_q <= rect.x1;
            y1_q <= rect.y1;
        end else if (drawing) begin
            if (px == x1_q) begin  // end of row
                px <= x0_q;
                py <= py + coord_t'(1);
            end else begin
                px <= px + coord_t'(1);
            end
        end
    end

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
            end else if (drawing && last_pix) begin
                busy <= 1'b0;
                done <= 1'b1;  // cycle after final pixel
            end
        end
    end

endmodule

`default_nettype wire

//--- framebuffer/framebuffer.sv
/*
 * framebuffer: colour-index memory written by the filler and read at
 * scaled screen position, palette lookup with matched sync delay
 */
`default_nettype none
`timescale 1ns/1ps

module framebuffer (
    input  wire logic                   clk_100m,
    input  wire logic                   rst_n,
    input  wire logic                   we,
    input  wire display_pkg::coord_t    wx,
    input  wire display_pkg::coord_t    wy,
    input  wire draw_pkg::cidx_t        wcidx,
    input  wire display_pkg::disp_sig_t timing,
    output display_pkg::disp_sig_t      disp,
    output display_pkg::rgb_t           rgb
);
    import display_pkg::*;
    import draw_pkg::*;

    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;

    cidx_t                mem [FB_PIXELS];
    cidx_t                cidx_rd;
    logic [FB_ADDRW-1:0]  waddr;
    logic [FB_ADDRW-1:0]  raddr;
    logic                 wr_ok;
    disp_sig_t            disp_p1;  // aligned with cidx_rd

    initial begin
        for (int i = 0; i < FB_PIXELS; i++) begin
            mem[i] = '0;
        end
    end

    always_comb begin
        wr_ok = we && (wx >= 0) && (wx < FB_WIDTH) && (wy >= 0) && (wy < FB_HEIGHT);
        waddr = FB_ADDRW'(wy * FB_WIDTH + wx);
        raddr = '0;
        if (timing.de) begin
            raddr = FB_ADDRW'((timing.sy / FB_SCALE) * FB_WIDTH + timing.sx / FB_SCALE);
        end
    end

    always_ff @(posedge clk_100m) begin
        if (wr_ok) mem[waddr] <= wcidx;  // off-screen writes dropped
        cidx_rd <= mem[raddr];
    end

    // two stages, memory read then palette
    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            disp_p1 <= '0;
            disp    <= '0;
            rgb     <= '0;
        end else begin
            disp_p1 <= timing;
            disp    <= disp_p1;
            rgb     <= disp_p1.de ? PALETTE[cidx_rd] : '0;  // black in blanking
        end
    end

endmodule

`default_nettype wire

//--- src/rect_display_top.sv
/*
 * filled rectangle display top: raster timing, shape sequencer,
 * rectangle filler and framebuffer scan-out
 */
`default_nettype none
`timescale 1ns/1ps

module rect_display_top (
    input  wire logic              clk_100m,
    input  wire logic              rst_n,
    output display_pkg::disp_sig_t disp,
    output display_pkg::rgb_t      rgb,
    output logic                   draw_done_all
);
    import display_pkg::*;
    import draw_pkg::*;

    disp_sig_t timing;
    rect_t     rect;
    logic      draw_start;
    logic      draw_oe;
    logic      draw_done;
    logic      drawing;     // framebuffer write strobe
    coord_t    px;
    coord_t    py;

    display_timing display_timing_inst (
        .clk_100m,
        .rst_n,
        .timing
    );

    shape_sequencer shape_sequencer_inst (
        .clk_100m,
        .rst_n,
        .frame         (timing.frame),
        .draw_done,
        .rect,
        .draw_start,
        .draw_oe,
        .draw_done_all
    );

    draw_rectangle_fill draw_rectangle_fill_inst (
        .clk_100m,
        .rst_n,
        .start   (draw_start),
        .oe      (draw_oe),
        .rect,
        .px,
        .py,
        .drawing,
        .done    (draw_done)
    );

    framebuffer framebuffer_inst (
        .clk_100m,
        .rst_n,
        .we     (drawing),
        .wx     (px),
        .wy     (py),
        .wcidx  (rect.cidx),  // colour of the current shape
        .timing,
        .disp,
        .rgb
    );

endmodule

`default_nettype wire

//--- tb/rect_display_chk.sv
/*
 * bound checker for the rectangle display: raster reference model,
 * blanking, drawing pace and final image against the rectangle rule
 */
`default_nettype none
`timescale 1ns/1ps

module rect_display_chk (
    input wire logic                   clk_100m,
    input wire logic                   rst_n,
    input wire display_pkg::disp_sig_t disp,
    input wire display_pkg::rgb_t      rgb,
    input wire logic                   draw_done_all
);
    import display_pkg::*;
    import draw_pkg::*;

    // 11 x 9 pixels per rectangle at no more than PIX_FRAME per frame
    localparam int RECT_PIX    = (14 - 4 + 1) * (10 - 2 + 1);
    localparam int DRAW_FRAMES = (SHAPE_CNT * RECT_PIX + PIX_FRAME - 1) / PIX_FRAME;
    // the first drawing window opens right after frame pulse FRAME_WAIT
    localparam int MIN_FRAMES  = FRAME_WAIT + DRAW_FRAMES - 1;

    int         mx;      // model raster position
    int         my;
    int         lx1;
    int         ly1;
    int         lx2;     // model position matching disp
    int         ly2;
    int         frames;  // frame pulses since reset
    int         err_cnt = 0;
    logic       rst_q;
    logic [2:0] done_q;
    logic       exp_de;
    logic       exp_hs;
    logic       exp_vs;
    logic       exp_fr;

    // highest shape covering the fb pixel wins, black elsewhere
    function automatic rgb_t expected_rgb(input int x, input int y);
        int fx;
        int fy;
        int c;
        fx = x / FB_SCALE;
        fy = y / FB_SCALE;
        c  = 0;
        for (int n = 0; n < SHAPE_CNT; n++) begin
            if (fx >= 4 + 2 * n && fx <= 14 + 2 * n && fy >= 2 + 2 * n && fy <= 10 + 2 * n) begin
                c = n + 1;
            end
        end
        return PALETTE[c];
    endfunction

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            mx     <= H_TOTAL - 1;  // raster parks at the last blanking pixel
            my     <= V_TOTAL - 1;
            lx1    <= H_TOTAL - 1;
            ly1    <= V_TOTAL - 1;
            lx2    <= H_TOTAL - 1;
            ly2    <= V_TOTAL - 1;
            frames <= 0;
            done_q <= '0;
        end else begin
            mx <= (mx == H_TOTAL - 1) ? 0 : mx + 1;
            if (mx == H_TOTAL - 1) my <= (my == V_TOTAL - 1) ? 0 : my + 1;
            lx1    <= mx;
            ly1    <= my;
            lx2    <= lx1;  // memory read plus palette stage
            ly2    <= ly1;
            if (mx == 0 && my == 0) frames <= frames + 1;
            done_q <= {done_q[1:0], draw_done_all};
        end
    end

    always_ff @(posedge clk_100m) rst_q <= rst_n;

    assign exp_de = (lx2 < H_ACTIVE) && (ly2 < V_ACTIVE);
    assign exp_hs = (lx2 >= H_SYNC_START) && (lx2 < H_SYNC_END);
    assign exp_vs = (ly2 >= V_SYNC_START) && (ly2 < V_SYNC_END);
    assign exp_fr = (lx2 == 0) && (ly2 == 0);

    reset_quiet: assert property (@(posedge clk_100m) (!rst_n || !rst_q) |->
        !(disp.de || disp.hsync || disp.vsync || disp.frame || draw_done_all))
        else begin
            err_cnt++;
            $error("[ERROR] reset_quiet expected 00000 actual %b%b%b%b%b",
                $sampled(disp.de), $sampled(disp.hsync), $sampled(disp.vsync),
                $sampled(disp.frame), $sampled(draw_done_all));
        end

    raster_de: assert property (@(posedge clk_100m) disable iff (!rst_n)
        disp.de == exp_de)
        else begin
            err_cnt++;
            $error("[ERROR] raster_de expected %b actual %b", $sampled(exp_de), $sampled(disp.de));
        end

    raster_sync: assert property (@(posedge clk_100m) disable iff (!rst_n)
        disp.hsync == exp_hs && disp.vsync == exp_vs && disp.frame == exp_fr)
        else begin
            err_cnt++;
            $error("[ERROR] raster_sync expected %b%b%b actual %b%b%b",
                $sampled(exp_hs), $sampled(exp_vs), $sampled(exp_fr),
                $sampled(disp.hsync), $sampled(disp.vsync), $sampled(disp.frame));
        end

    // screen position carried alongside the colour
    raster_pos: assert property (@(posedge clk_100m) disable iff (!rst_n)
        disp.de |-> disp.sx == coord_t'(lx2) && disp.sy == coord_t'(ly2))
        else begin
            err_cnt++;
            $error("[ERROR] raster_pos expected (%0d,%0d) actual (%0d,%0d)", $sampled(lx2),
                $sampled(ly2), $sampled(disp.sx), $sampled(disp.sy));
        end

    blanking: assert property (@(posedge clk_100m) disable iff (!rst_n)
        !disp.de |-> rgb == '0)
        else begin
            err_cnt++;
            $error("[ERROR] blanking expected 000 actual %h", $sampled(rgb));
        end

    draw_pace: assert property (@(posedge clk_100m) disable iff (!rst_n)
        (draw_done_all && !done_q[0]) |-> frames >= MIN_FRAMES)
        else begin
            err_cnt++;
            $error("[ERROR] draw_pace expected >= %0d frames actual %0d", MIN_FRAMES,
                $sampled(frames));
        end

    // a few cycles of margin so the last write has reached the read path
    final_image: assert property (@(posedge clk_100m) disable iff (!rst_n)
        (done_q[2] && disp.de) |-> rgb == expected_rgb(lx2, ly2))
        else begin
            err_cnt++;
            $error("[ERROR] final_image at (%0d,%0d) expected %h actual %h", $sampled(lx2),
                $sampled(ly2), expected_rgb($sampled(lx2), $sampled(ly2)), $sampled(rgb));
        end

endmodule

bind rect_display_top rect_display_chk rect_display_chk_inst (
    .clk_100m      (clk_100m),
    .rst_n         (rst_n),
    .disp          (disp),
    .rgb           (rgb),
    .draw_done_all (draw_done_all)
);

`default_nettype wire

//--- tb/tb_rect_display.sv
/*
 * testbench for the rectangle display: clock, reset, waits for the
 * drawing to finish and watches a few frames of the final image
 */
`default_nettype none
`timescale 1ns/1ps

module tb_rect_display;
    import display_pkg::*;

    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int DONE_TIMEOUT = 20 * FRAME_CYCLES;  // well past the slowest pace

    logic      clk_100m;
    logic      rst_n;
    disp_sig_t disp;
    rgb_t      rgb;
    logic      draw_done_all;
    int        extra_frames;

    rect_display_top rect_display_top_inst (
        .clk_100m,
        .rst_n,
        .disp,
        .rgb,
        .draw_done_all
    );

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;
    end

    // any checker failure ends the run at once
    always @(negedge clk_100m) begin
        if (rect_display_top_inst.rect_display_chk_inst.err_cnt != 0) begin
            $display(">>> FAIL");
            $fatal(1, "an assertion in the checker failed");
        end
    end

    task automatic wait_draw_done(input int limit);
        int n;
        n = 0;
        while (draw_done_all !== 1'b1) begin
            @(negedge clk_100m);
            n++;
            if (n > limit) begin
                $display(">>> FAIL");
                $fatal(1, "timed out waiting for the drawing to finish");
            end
        end
    endtask

    task automatic wait_frame_pulse(input int limit);
        int n;
        n = 0;
        do begin
            @(negedge clk_100m);
            n++;
            if (n > limit) begin
                $display(">>> FAIL");
                $fatal(1, "timed out waiting for a frame pulse");
            end
        end while (disp.frame !== 1'b1);
    endtask

    initial begin
        rst_n = 1'b0;
        void'($urandom(26));
        extra_frames = 1 + ($urandom % 3);
        repeat (5) @(posedge clk_100m);
        rst_n <= 1'b1;

        wait_draw_done(DONE_TIMEOUT);
        // one pulse to reach a frame start, then whole frames of the image
        repeat (extra_frames + 1) wait_frame_pulse(FRAME_CYCLES + 10);
        repeat (4) @(negedge clk_100m);

        if (rect_display_top_inst.rect_display_chk_inst.err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
common/display_pkg.sv
common/draw_pkg.sv
src/display_timing.sv
draw/shape_sequencer.sv
draw/draw_rectangle_fill.sv
framebuffer/framebuffer.sv
src/rect_display_top.sv
tb/rect_display_chk.sv
tb/tb_rect_display.sv

//--- Makefile
SIM  := obj_dir/Vtb_rect_display
SRCS := $(wildcard common/*.sv src/*.sv draw/*.sv framebuffer/*.sv tb/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): vlog.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_rect_display -f vlog.f

run: $(SIM)
	$(SIM) +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
